// ==== logic/rv_pkg.sv ====
//////////////////////////////
// widths, opcodes and ALU codes shared by the RV32I slice
// modules refer to these by scoped name
//////////////////////////////
`default_nettype none

package rv_pkg;

    // basic widths
    localparam int xlen_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    typedef logic [xlen_w-1:0]     xlen_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [31:0]           inst_t;

    // major opcodes handled by the slice
    typedef logic [6:0] opcode_t;

    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_auipc = 7'b0010111;
    localparam opcode_t op_imm   = 7'b0010011;
    localparam opcode_t op_reg   = 7'b0110011;

    // funct3 for OP and OP-IMM
    typedef logic [2:0] funct3_t;

    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // ALU operation, low codes follow funct3 where they can
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_add    = 4'h0;
    localparam alu_op_t alu_sll    = 4'h1;
    localparam alu_op_t alu_slt    = 4'h2;
    localparam alu_op_t alu_sltu   = 4'h3;
    localparam alu_op_t alu_xor    = 4'h4;
    localparam alu_op_t alu_srl    = 4'h5;
    localparam alu_op_t alu_or     = 4'h6;
    localparam alu_op_t alu_and    = 4'h7;
    localparam alu_op_t alu_sub    = 4'h8;
    localparam alu_op_t alu_sra    = 4'hd;
    localparam alu_op_t alu_pass_b = 4'hf;

    // operand selects
    typedef logic [0:0] src_a_sel_t;

    localparam src_a_sel_t src_a_rs1 = 1'b0;
    localparam src_a_sel_t src_a_pc  = 1'b1;

    typedef logic [0:0] src_b_sel_t;

    localparam src_b_sel_t src_b_rs2 = 1'b0;
    localparam src_b_sel_t src_b_imm = 1'b1;

endpackage

`default_nettype wire

// ==== logic/rv_decode.sv ====
//////////////////////////////
// decode stage: latches the instruction word and pc,
// then derives ALU controls, operand selects and immediate
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  rv_pkg::inst_t      in_inst,
    input  rv_pkg::xlen_t      in_pc,
    output logic               dec_valid,
    output rv_pkg::xlen_t      dec_pc,
    output rv_pkg::reg_addr_t  dec_rd,
    output rv_pkg::alu_op_t    alu_op,
    output rv_pkg::src_a_sel_t src_a_sel,
    output rv_pkg::src_b_sel_t src_b_sel,
    output rv_pkg::xlen_t      imm,
    output logic               reg_we,
    output logic               illegal
);

    rv_pkg::inst_t   inst_q;
    rv_pkg::opcode_t opcode;
    rv_pkg::funct3_t funct3;
    logic            funct7_b5;
    rv_pkg::xlen_t   i_imm;
    rv_pkg::xlen_t   u_imm;

    // map funct3 to an ALU operation; sub only exists for OP
    function automatic rv_pkg::alu_op_t alu_from_f3(
        input rv_pkg::funct3_t f3,
        input logic            alt,
        input logic            sub_ok
    );
        rv_pkg::alu_op_t op;
        case (f3)
            rv_pkg::f3_add:  op = (alt && sub_ok) ? rv_pkg::alu_sub : rv_pkg::alu_add;
            rv_pkg::f3_sll:  op = rv_pkg::alu_sll;
            rv_pkg::f3_slt:  op = rv_pkg::alu_slt;
            rv_pkg::f3_sltu: op = rv_pkg::alu_sltu;
            rv_pkg::f3_xor:  op = rv_pkg::alu_xor;
            rv_pkg::f3_sr:   op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            rv_pkg::f3_or:   op = rv_pkg::alu_or;
            rv_pkg::f3_and:  op = rv_pkg::alu_and;
            default:         op = rv_pkg::alu_add;
        endcase
        return op;
    endfunction

    // valid follows every beat, word and pc only load on a beat
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            inst_q <= in_inst;
            dec_pc <= in_pc;
        end
    end

    // instruction fields
    assign opcode    = inst_q[6:0];
    assign funct3    = inst_q[14:12];
    assign funct7_b5 = inst_q[30];
    assign dec_rd    = inst_q[11:7];

    // I-type covers shamt too, ALU only looks at the low 5 bits
    assign i_imm = {{20{inst_q[31]}}, inst_q[31:20]};
    assign u_imm = {inst_q[31:12], 12'h000};

    // control table
    always_comb begin
        alu_op    = rv_pkg::alu_add;
        src_a_sel = rv_pkg::src_a_rs1;
        src_b_sel = rv_pkg::src_b_imm;
        imm       = i_imm;
        reg_we    = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            rv_pkg::op_lui: begin
                alu_op = rv_pkg::alu_pass_b;
                imm    = u_imm;
                reg_we = 1'b1;
            end
            rv_pkg::op_auipc: begin
                alu_op    = rv_pkg::alu_add;
                src_a_sel = rv_pkg::src_a_pc;
                imm       = u_imm;
                reg_we    = 1'b1;
            end
            rv_pkg::op_imm: begin
                alu_op = alu_from_f3(funct3, funct7_b5, 1'b0);
                reg_we = 1'b1;
            end
            rv_pkg::op_reg: begin
                alu_op    = alu_from_f3(funct3, funct7_b5, 1'b1);
                src_b_sel = rv_pkg::src_b_rs2;
                reg_we    = 1'b1;
            end
            default: begin
                // anything else is reported, never written back
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
//////////////////////////////
// 32 x 32 register file, registered reads with write-first bypass
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_en,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::xlen_t     rs1_data,
    output rv_pkg::xlen_t     rs2_data,
    input  logic              wb_en,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::xlen_t     wb_data
);

    rv_pkg::xlen_t regs [rv_pkg::num_regs];
    logic          wr_live;
    logic          byp1;
    logic          byp2;

    // x0 is never written, so it stays at its reset value
    assign wr_live = wb_en && (wb_rd != '0);
    assign byp1    = wr_live && (wb_rd == rs1);
    assign byp2    = wr_live && (wb_rd == rs2);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // same-edge write wins over the stored value
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rs1_data <= byp1 ? wb_data : regs[rs1];
            rs2_data <= byp2 ? wb_data : regs[rs2];
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
//////////////////////////////
// execute stage: ALU, writeback drive and result record register
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic               clk,
    input  logic               rst,
    input  logic               dec_valid,
    input  rv_pkg::xlen_t      dec_pc,
    input  rv_pkg::reg_addr_t  dec_rd,
    input  rv_pkg::alu_op_t    alu_op,
    input  rv_pkg::src_a_sel_t src_a_sel,
    input  rv_pkg::src_b_sel_t src_b_sel,
    input  rv_pkg::xlen_t      imm,
    input  logic               reg_we,
    input  logic               illegal,
    input  rv_pkg::xlen_t      rs1_data,
    input  rv_pkg::xlen_t      rs2_data,
    output logic               wb_en,
    output rv_pkg::reg_addr_t  wb_rd,
    output rv_pkg::xlen_t      wb_data,
    output logic               res_push,
    output rv_pkg::reg_addr_t  res_rd,
    output rv_pkg::xlen_t      res_data,
    output rv_pkg::xlen_t      res_pc,
    output logic               res_illegal
);

    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t alu_res;
    logic [4:0]    shamt;

    assign op_a  = (src_a_sel == rv_pkg::src_a_pc) ? dec_pc : rs1_data;
    assign op_b  = (src_b_sel == rv_pkg::src_b_imm) ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:    alu_res = op_a + op_b;
            rv_pkg::alu_sub:    alu_res = op_a - op_b;
            rv_pkg::alu_sll:    alu_res = op_a << shamt;
            rv_pkg::alu_xor:    alu_res = op_a ^ op_b;
            rv_pkg::alu_srl:    alu_res = op_a >> shamt;
            rv_pkg::alu_sra:    alu_res = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::alu_or:     alu_res = op_a | op_b;
            rv_pkg::alu_and:    alu_res = op_a & op_b;
            rv_pkg::alu_slt:    alu_res = rv_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            rv_pkg::alu_sltu:   alu_res = rv_pkg::xlen_t'(op_a < op_b);
            rv_pkg::alu_pass_b: alu_res = op_b;
            default:            alu_res = '0;
        endcase
    end

    // writeback lands in the register file at the next edge
    assign wb_en   = dec_valid && reg_we;
    assign wb_rd   = dec_rd;
    assign wb_data = alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_push <= 1'b0;
        end else begin
            res_push <= dec_valid;
        end
    end

    // result record, illegal ops carry zero data
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            res_rd      <= dec_rd;
            res_data    <= illegal ? '0 : alu_res;
            res_pc      <= dec_pc;
            res_illegal <= illegal;
        end
    end

endmodule

`default_nettype wire

// ==== logic/result_queue.sv ====
//////////////////////////////
// result FIFO, pops against downstream credits
// and returns one upstream credit per pop
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module result_queue #(
    parameter int IN_CREDITS   = 4,
    parameter int DOWN_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              res_push,
    input  rv_pkg::reg_addr_t res_rd,
    input  rv_pkg::xlen_t     res_data,
    input  rv_pkg::xlen_t     res_pc,
    input  logic              res_illegal,
    input  logic              out_credit,
    output logic              out_valid,
    output rv_pkg::reg_addr_t out_rd,
    output rv_pkg::xlen_t     out_data,
    output rv_pkg::xlen_t     out_pc,
    output logic              out_illegal,
    output logic              in_credit
);

    localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
    localparam int CNT_W = $clog2(IN_CREDITS + 1);
    localparam int CRD_W = $clog2(DOWN_CREDITS + 1);

    rv_pkg::reg_addr_t mem_rd      [IN_CREDITS];
    rv_pkg::xlen_t     mem_data    [IN_CREDITS];
    rv_pkg::xlen_t     mem_pc      [IN_CREDITS];
    logic              mem_illegal [IN_CREDITS];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] credits;
    logic             empty;
    logic             pop;
    logic             wr_en;
    logic             rd_adv;

    // an empty queue hands the incoming push straight to the output
    assign empty  = (count == '0);
    assign pop    = (!empty || res_push) && (credits != '0);
    assign wr_en  = res_push && !(empty && pop);
    assign rd_adv = pop && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_rd[wr_ptr]      <= res_rd;
            mem_data[wr_ptr]    <= res_data;
            mem_pc[wr_ptr]      <= res_pc;
            mem_illegal[wr_ptr] <= res_illegal;
        end
    end

    // pointers wrap at IN_CREDITS, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (rd_adv) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            if (wr_en && !rd_adv) begin
                count <= count + CNT_W'(1);
            end else if (rd_adv && !wr_en) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    // downstream credit counter
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRD_W'(DOWN_CREDITS);
        end else if (pop && !out_credit) begin
            credits <= credits - CRD_W'(1);
        end else if (out_credit && !pop) begin
            credits <= credits + CRD_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            out_rd      <= empty ? res_rd      : mem_rd[rd_ptr];
            out_data    <= empty ? res_data    : mem_data[rd_ptr];
            out_pc      <= empty ? res_pc      : mem_pc[rd_ptr];
            out_illegal <= empty ? res_illegal : mem_illegal[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_exec_slice.sv ====
//////////////////////////////
// top of the RV32I decode/execute slice with credit handshakes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv_exec_slice #(
    parameter int IN_CREDITS   = 4,
    parameter int DOWN_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  rv_pkg::inst_t     in_inst,
    input  rv_pkg::xlen_t     in_pc,
    output logic              in_credit,
    output logic              out_valid,
    output rv_pkg::reg_addr_t out_rd,
    output rv_pkg::xlen_t     out_data,
    output rv_pkg::xlen_t     out_pc,
    output logic              out_illegal,
    input  logic              out_credit
);

    // decode to execute
    logic               dec_valid;
    rv_pkg::xlen_t      dec_pc;
    rv_pkg::reg_addr_t  dec_rd;
    rv_pkg::alu_op_t    alu_op;
    rv_pkg::src_a_sel_t src_a_sel;
    rv_pkg::src_b_sel_t src_b_sel;
    rv_pkg::xlen_t      imm;
    logic               reg_we;
    logic               illegal;

    // register file ports
    rv_pkg::xlen_t      rs1_data;
    rv_pkg::xlen_t      rs2_data;
    logic               wb_en;
    rv_pkg::reg_addr_t  wb_rd;
    rv_pkg::xlen_t      wb_data;

    // execute to queue
    logic               res_push;
    rv_pkg::reg_addr_t  res_rd;
    rv_pkg::xlen_t      res_data;
    rv_pkg::xlen_t      res_pc;
    logic               res_illegal;

    rv_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_pc     (in_pc),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_rd    (dec_rd),
        .alu_op    (alu_op),
        .src_a_sel (src_a_sel),
        .src_b_sel (src_b_sel),
        .imm       (imm),
        .reg_we    (reg_we),
        .illegal   (illegal)
    );

    // operands are read from the raw word on the accept edge
    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (in_valid),
        .rs1      (in_inst[19:15]),
        .rs2      (in_inst[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    rv_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_rd      (dec_rd),
        .alu_op      (alu_op),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .imm         (imm),
        .reg_we      (reg_we),
        .illegal     (illegal),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .res_push    (res_push),
        .res_rd      (res_rd),
        .res_data    (res_data),
        .res_pc      (res_pc),
        .res_illegal (res_illegal)
    );

    result_queue #(
        .IN_CREDITS   (IN_CREDITS),
        .DOWN_CREDITS (DOWN_CREDITS)
    ) u_result_queue (
        .clk         (clk),
        .rst         (rst),
        .res_push    (res_push),
        .res_rd      (res_rd),
        .res_data    (res_data),
        .res_pc      (res_pc),
        .res_illegal (res_illegal),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_pc      (out_pc),
        .out_illegal (out_illegal),
        .in_credit   (in_credit)
    );

endmodule

`default_nettype wire

// ==== verif/tb_rv_exec_slice.sv ====
//////////////////////////////
// directed testbench for the RV32I slice that checks results
// against a register model and drives both credit loops
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_slice;

    localparam int num_in_credits   = 4;
    localparam int num_down_credits = 2;
    localparam int wait_limit       = 500;

    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_op    = 7'b0110011;
    localparam logic [6:0] opc_load  = 7'b0000011;

    localparam logic [2:0] fn_add  = 3'd0;
    localparam logic [2:0] fn_sll  = 3'd1;
    localparam logic [2:0] fn_slt  = 3'd2;
    localparam logic [2:0] fn_sltu = 3'd3;
    localparam logic [2:0] fn_xor  = 3'd4;
    localparam logic [2:0] fn_sr   = 3'd5;
    localparam logic [2:0] fn_or   = 3'd6;
    localparam logic [2:0] fn_and  = 3'd7;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_inst;
    logic [31:0] in_pc;
    logic        in_credit;
    logic        out_valid;
    logic [4:0]  out_rd;
    logic [31:0] out_data;
    logic [31:0] out_pc;
    logic        out_illegal;
    logic        out_credit = 1'b0;

    // reference model and expected results in issue order
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_pc [$];
    logic        exp_ill [$];
    int          credit_due [$];

    int          errors;
    int          timeouts;
    int          up_credits;
    int          send_stalls;
    int          results_seen;
    int          credit_pulses;
    int          held_credits;
    int          credit_delay;
    int          cycle;
    bit          withhold;
    logic [31:0] next_pc;
    integer      seed;

    rv_exec_slice #(
        .IN_CREDITS   (num_in_credits),
        .DOWN_CREDITS (num_down_credits)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_pc       (in_pc),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_rd      (out_rd),
        .out_data    (out_data),
        .out_pc      (out_pc),
        .out_illegal (out_illegal),
        .out_credit  (out_credit)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input int rd,
                                          input logic [2:0] f3, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc_op};
    endfunction

    // ISA semantics of the OP / OP-IMM group
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            fn_add:  r = alt ? a - b : a + b;
            fn_sll:  r = a << sh;
            fn_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fn_sltu: r = (a < b) ? 32'd1 : 32'd0;
            fn_xor:  r = a ^ b;
            // arithmetic shift fills the vacated bits with the sign
            fn_sr:   r = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
            fn_or:   r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic model_step(input logic [31:0] inst, input logic [31:0] pc);
        logic [31:0] r;
        logic        ill;
        logic [2:0]  f3;
        f3  = inst[14:12];
        ill = 1'b0;
        case (inst[6:0])
            opc_lui:   r = {inst[31:12], 12'h000};
            opc_auipc: r = pc + {inst[31:12], 12'h000};
            opc_imm:   r = ref_alu(f3, (f3 == fn_sr) && inst[30], model_regs[inst[19:15]],
                                   {{20{inst[31]}}, inst[31:20]});
            opc_op:    r = ref_alu(f3, inst[30], model_regs[inst[19:15]],
                                   model_regs[inst[24:20]]);
            default: begin
                ill = 1'b1;
                r   = 32'h0;
            end
        endcase
        if (!ill && inst[11:7] != 5'd0) begin
            model_regs[inst[11:7]] = r;
        end
        exp_rd.push_back(inst[11:7]);
        exp_data.push_back(r);
        exp_pc.push_back(pc);
        exp_ill.push_back(ill);
    endtask

    // one beat per call and only while an upstream credit is held
    task automatic send(input logic [31:0] inst);
        int waited;
        waited = 0;
        while (up_credits == 0 && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (up_credits == 0) begin
            $display("timeout: no upstream credit came back for instruction %h", inst);
            timeouts++;
        end else begin
            send_stalls += waited;
            model_step(inst, next_pc);
            in_valid = 1'b1;
            in_inst  = inst;
            in_pc    = next_pc;
            up_credits--;
            next_pc += 32'd4;
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_data.size() != 0) begin
            $display("timeout: %0d results never came out of the slice", exp_data.size());
            timeouts++;
            exp_rd.delete();
            exp_data.delete();
            exp_pc.delete();
            exp_ill.delete();
        end
    endtask

    // output monitor and upstream credit return
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit) begin
                up_credits++;
                credit_pulses++;
            end
            if (out_valid) begin
                results_seen++;
                if (withhold) begin
                    held_credits++;
                end else begin
                    credit_due.push_back(cycle + credit_delay);
                end
                if (exp_data.size() == 0) begin
                    $display("unexpected result at %0t ns for rd %0d", $time, out_rd);
                    errors++;
                end else begin
                    check_value("out_rd", 32'(exp_rd.pop_front()), 32'(out_rd));
                    check_value("out_data", exp_data.pop_front(), out_data);
                    check_value("out_pc", exp_pc.pop_front(), out_pc);
                    check_value("out_illegal", 32'(exp_ill.pop_front()), 32'(out_illegal));
                end
            end
        end
    end

    // downstream responder with at most one credit pulse per cycle
    always @(posedge clk) begin
        #1;
        cycle++;
        if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
            out_credit = 1'b1;
            void'(credit_due.pop_front());
        end else begin
            out_credit = 1'b0;
        end
    end

    task automatic idle_outputs_low();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("out_valid", 32'd0, 32'(out_valid));
            check_value("in_credit", 32'd0, 32'(in_credit));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic upper_and_imm_ops();
        send({20'h12345, 5'd1, opc_lui});
        send({20'hfffff, 5'd2, opc_auipc});
        send(enc_i(opc_imm, 3, fn_add, 1, -1));
        send(enc_i(opc_imm, 4, fn_slt, 2, 5));
        send(enc_i(opc_imm, 5, fn_sltu, 0, 1));
        send(enc_i(opc_imm, 6, fn_xor, 1, -1));
        send(enc_i(opc_imm, 7, fn_or, 3, 'h0f0));
        send(enc_i(opc_imm, 8, fn_and, 6, 'h7ff));
        send(enc_i(opc_imm, 9, fn_sll, 1, 4));
        send(enc_i(opc_imm, 10, fn_sr, 6, 8));
        send(enc_i(opc_imm, 11, fn_sr, 6, 'h408));
        drain();
    endtask

    // groups of four fit the upstream credits so each group issues back to back
    task automatic dependent_chains();
        send_stalls = 0;
        send(enc_i(opc_imm, 17, fn_add, 0, 3));
        send(enc_i(opc_imm, 13, fn_add, 0, -7));
        send(enc_r(7'h00, fn_add, 14, 13, 13));
        send(enc_r(7'h20, fn_add, 15, 14, 17));
        drain();
        send(enc_r(7'h20, fn_sr, 16, 15, 17));
        send(enc_r(7'h00, fn_sr, 18, 16, 17));
        send(enc_r(7'h00, fn_slt, 20, 16, 17));
        send(enc_r(7'h00, fn_sltu, 21, 16, 17));
        drain();
        send(enc_r(7'h00, fn_xor, 22, 20, 16));
        send(enc_r(7'h00, fn_or, 23, 22, 15));
        send(enc_r(7'h00, fn_and, 24, 23, 14));
        send(enc_r(7'h00, fn_sll, 25, 24, 17));
        drain();
        check_value("send_stalls", 32'd0, 32'(send_stalls));
    endtask

    task automatic x0_and_illegal();
        send(enc_i(opc_imm, 0, fn_add, 0, 5));
        send(enc_r(7'h00, fn_add, 0, 17, 17));
        send(enc_i(opc_imm, 26, fn_add, 0, 0));
        // a load is outside the slice and must not touch x17
        send(enc_i(opc_load, 17, 3'b010, 0, 4));
        send(enc_i(opc_imm, 27, fn_add, 17, 0));
        drain();
    endtask

    task automatic credit_backpressure();
        int base_results;
        int base_pulses;
        int waited;
        base_results = results_seen;
        base_pulses  = credit_pulses;
        withhold     = 1'b1;
        for (int i = 0; i < 4; i++) begin
            send(enc_i(opc_imm, 28, fn_add, 28, 7));
        end
        waited = 0;
        while (results_seen - base_results < num_down_credits && waited < wait_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (results_seen - base_results < num_down_credits) begin
            $display("timeout: results never used up the downstream credits");
            timeouts++;
        end
        repeat (12) @(posedge clk);
        #1;
        check_value("results while withheld", 32'(num_down_credits),
                    32'(results_seen - base_results));
        // release away from the responder edge
        @(negedge clk);
        withhold = 1'b0;
        while (held_credits > 0) begin
            credit_due.push_back(cycle);
            held_credits--;
        end
        drain();
        check_value("results after release", 32'd4, 32'(results_seen - base_results));
        check_value("in_credit pulses", 32'd4, 32'(credit_pulses - base_pulses));
    endtask

    task automatic random_stream();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        credit_delay = 2;
        for (int n = 0; n < 200; n++) begin
            r  = $random(seed);
            f3 = r[2:0];
            if (r[3]) begin
                f7 = ((f3 == fn_add || f3 == fn_sr) && r[4]) ? 7'h20 : 7'h00;
                send(enc_r(f7, f3, int'(r[9:5]), int'(r[14:10]), int'(r[19:15])));
            end else begin
                imm = r[31:20];
                if (f3 == fn_sll || f3 == fn_sr) begin
                    imm[11:5] = (f3 == fn_sr && r[4]) ? 7'h20 : 7'h00;
                end
                send(enc_i(opc_imm, int'(r[9:5]), f3, int'(r[14:10]), int'(imm)));
            end
        end
        drain();
        credit_delay = 0;
    endtask

    initial begin
        seed          = 87235;
        errors        = 0;
        timeouts      = 0;
        up_credits    = num_in_credits;
        send_stalls   = 0;
        results_seen  = 0;
        credit_pulses = 0;
        held_credits  = 0;
        credit_delay  = 0;
        cycle         = 0;
        withhold      = 1'b0;
        next_pc       = 32'h0000_1000;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_inst       = 32'h0;
        in_pc         = 32'h0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        idle_outputs_low();
        upper_and_imm_ops();
        dependent_chains();
        x0_and_illegal();
        credit_backpressure();
        random_stream();

        $display("failed checks: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/rv_pkg.sv
logic/rv_decode.sv
logic/reg_file.sv
logic/rv_execute.sv
logic/result_queue.sv
logic/rv_exec_slice.sv
verif/tb_rv_exec_slice.sv

// ==== Makefile ====
TOP := tb_rv_exec_slice

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir
